// File: Makefile
# Verilator build and run of the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= icache_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= Simulation PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hw/icache_data_array.sv
// line storage for both ways, written a whole line at a time and read one word at a time
`timescale 1ns/1ps

module icache_data_array #(
    parameter int index_width  = 4,
    parameter int offset_width = 2
) (
    input  logic                            clk,
    input  icache_pkg::addr_t               addr,
    input  logic [1:0]                      we,
    input  logic [(32 << offset_width)-1:0] wline,
    input  logic                            way,
    output icache_pkg::word_t               word
);
    import icache_pkg::*;

    localparam int line_width = 32 << offset_width;
    localparam int sets       = 1 << index_width;

    logic [index_width-1:0]  index;
    logic [offset_width-1:0] offset;
    word_t                   way_word [2];

    assign index  = addr[2+offset_width +: index_width];
    assign offset = addr[2 +: offset_width];

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic [line_width-1:0] line_q [sets];

        always_ff @(posedge clk) begin
            if (we[w]) begin
                line_q[index] <= wline;
            end
        end

        // word within the line picked by the address offset
        assign way_word[w] = line_q[index][{offset, 5'b0} +: 32];
    end

    assign word = way_word[way];

endmodule

// File: hw/icache_lru.sv
// per-set LRU bit of the two-way cache, naming the way to replace on refill
`timescale 1ns/1ps

module icache_lru #(
    parameter int index_width = 4
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [index_width-1:0] index,
    input  logic                   use0,
    input  logic                   use1,
    output logic                   victim
);
    localparam int sets = 1 << index_width;

    // most recently used way of each set
    logic [sets-1:0] mru_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mru_q <= '0;
        end else if (use1) begin
            mru_q[index] <= 1'b1;
        end else if (use0) begin
            mru_q[index] <= 1'b0;
        end
    end

    assign victim = ~mru_q[index];

endmodule

// File: hw/icache_main_fsm.sv
// main controller of the instruction cache, sequencing lookup, refill, flush and cache operations
`timescale 1ns/1ps

module icache_main_fsm (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 valid,
    input  logic                 stall,
    input  logic                 flush,
    input  logic                 opflag,
    input  logic                 rbuf_opflag,
    input  icache_pkg::cacheop_t rbuf_op,
    input  logic                 rbuf_barrier,
    input  logic                 rbuf_uncached,
    input  logic                 rbuf_way,
    input  logic [1:0]           hit,
    input  logic                 victim,
    input  logic                 mem_addr_ok,
    input  logic                 mem_data_ok,
    output logic                 ready,
    output logic                 inst_valid,
    output logic                 mem_req,
    output logic                 rbuf_we,
    output logic                 use0,
    output logic                 use1,
    output logic [1:0]           data_we,
    output logic [1:0]           invalidate,
    output logic                 choose_way,
    output logic                 choose_return,
    output logic                 send_nop
);
    import icache_pkg::*;

    icache_state_t state;
    icache_state_t state_next;
    icache_state_t accept_state;
    logic          rst_done;
    logic          ready_raw;
    logic          accept;
    logic          any_hit;

    // ready stays low for one cycle after reset release
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rst_done <= 1'b0;
        end else begin
            rst_done <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    assign any_hit      = |hit;
    assign ready        = ready_raw & rst_done;
    assign accept       = valid & ready;
    assign accept_state = opflag ? st_operation : st_lookup;

    ////////////////////////////////////////////////////////////
    // ready, kept apart from the handshake it feeds
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (state)
            st_idle:      ready_raw = 1'b1;
            st_lookup:    ready_raw = !flush && !rbuf_uncached && any_hit && !stall;
            st_miss_wait: ready_raw = mem_data_ok && !stall;
            st_flush:     ready_raw = 1'b1;
            default:      ready_raw = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // next state and strobes
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_next    = state;
        inst_valid    = 1'b0;
        mem_req       = 1'b0;
        rbuf_we       = 1'b0;
        use0          = 1'b0;
        use1          = 1'b0;
        data_we       = 2'b00;
        invalidate    = 2'b00;
        choose_way    = hit[1];
        choose_return = 1'b0;
        send_nop      = 1'b0;
        case (state)
            st_idle: begin
                if (accept) begin
                    rbuf_we    = 1'b1;
                    state_next = accept_state;
                end
            end
            st_lookup: begin
                if (flush) begin
                    // pending result becomes a nop
                    inst_valid = 1'b1;
                    send_nop   = 1'b1;
                    state_next = st_flush;
                end else if (rbuf_uncached) begin
                    // drop any cached copy, then read around the cache
                    invalidate = hit;
                    state_next = st_miss_req;
                end else if (!any_hit) begin
                    state_next = st_miss_req;
                end else begin
                    inst_valid = 1'b1;
                    if (!stall) begin
                        use0       = hit[0];
                        use1       = hit[1];
                        rbuf_we    = accept;
                        state_next = accept ? accept_state : st_idle;
                    end
                end
            end
            st_miss_req: begin
                mem_req = 1'b1;
                if (mem_addr_ok) begin
                    state_next = st_miss_wait;
                end
            end
            st_miss_wait: begin
                if (mem_data_ok) begin
                    inst_valid    = 1'b1;
                    choose_return = 1'b1;
                    if (!rbuf_uncached) begin
                        data_we = victim ? 2'b10 : 2'b01;
                        use0    = !victim;
                        use1    = victim;
                    end
                    // a stalled return is presented again from the array or memory
                    if (stall) begin
                        state_next = rbuf_uncached ? st_miss_req : st_lookup;
                    end else begin
                        rbuf_we    = accept;
                        state_next = accept ? accept_state : st_idle;
                    end
                end
            end
            st_flush: begin
                send_nop = 1'b1;
                if (!flush) begin
                    rbuf_we    = accept;
                    state_next = accept ? accept_state : st_idle;
                end
            end
            st_operation: begin
                // barrier has nothing to order, so it falls through as a no-op
                if (rbuf_opflag && !rbuf_barrier) begin
                    case (rbuf_op)
                        op_index_init,
                        op_index_inv: invalidate = rbuf_way ? 2'b10 : 2'b01;
                        op_hit_inv:   invalidate = hit;
                        default:      invalidate = 2'b00;
                    endcase
                end
                state_next = st_idle;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

endmodule

// File: hw/icache_pkg.sv
// shared types, controller states and constants for the instruction cache, imported by its blocks
package icache_pkg;

    ////////////////////////////////////////////////////////////
    // widths with a meaning
    ////////////////////////////////////////////////////////////

    // fetch or operation address
    typedef logic [31:0] addr_t;

    // one instruction word
    typedef logic [31:0] word_t;

    // cache operation code, opcode bits 4:3
    typedef logic [1:0] cacheop_t;

    localparam cacheop_t op_index_init = 2'd0;
    localparam cacheop_t op_index_inv  = 2'd1;
    localparam cacheop_t op_hit_inv    = 2'd2;

    ////////////////////////////////////////////////////////////
    // controller
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_miss_req,
        st_miss_wait,
        st_flush,
        st_operation
    } icache_state_t;

    // andi r0, r0, 0 handed back for a flushed fetch
    localparam word_t NOP_WORD = 32'h0340_0000;

endpackage

// File: hw/icache_req_buf.sv
// request buffer of the instruction cache, capturing and decoding the accepted request once
`timescale 1ns/1ps

module icache_req_buf (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 we,
    input  icache_pkg::addr_t    addr,
    input  logic                 opflag,
    input  icache_pkg::word_t    opcode,
    output icache_pkg::addr_t    rbuf_addr,
    output logic                 rbuf_opflag,
    output icache_pkg::cacheop_t rbuf_op,
    output logic                 rbuf_barrier,
    output logic                 rbuf_uncached,
    output logic                 rbuf_way
);
    import icache_pkg::*;

    addr_t    addr_q;
    logic     opflag_q;
    cacheop_t op_q;
    logic     barrier_q;
    logic     uncached_q;

    // address is payload
    always_ff @(posedge clk) begin
        if (we) begin
            addr_q <= addr;
        end
    end

    ////////////////////////////////////////////////////////////
    // decoded fields
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            opflag_q   <= 1'b0;
            op_q       <= op_index_init;
            barrier_q  <= 1'b0;
            uncached_q <= 1'b0;
        end else if (we) begin
            opflag_q   <= opflag;
            op_q       <= cacheop_t'(opcode[4:3]);
            // bit 31 only means barrier on an operation
            barrier_q  <= opflag & opcode[31];
            // upper half of the space bypasses the cache
            uncached_q <= addr[31];
        end
    end

    assign rbuf_addr     = addr_q;
    assign rbuf_opflag   = opflag_q;
    assign rbuf_op       = op_q;
    assign rbuf_barrier  = barrier_q;
    assign rbuf_uncached = uncached_q;
    // index operations name the way in address bit 0
    assign rbuf_way      = addr_q[0];

endmodule

// File: hw/icache_tagv_array.sv
// tag and valid storage for both ways, giving the hit vector of the buffered address
`timescale 1ns/1ps

module icache_tagv_array #(
    parameter int index_width  = 4,
    parameter int offset_width = 2
) (
    input  logic              clk,
    input  logic              rstn,
    input  icache_pkg::addr_t addr,
    input  logic [1:0]        we,
    input  logic [1:0]        invalidate,
    output logic [1:0]        hit
);
    localparam int tag_width = 32 - index_width - offset_width - 2;
    localparam int sets      = 1 << index_width;

    logic [index_width-1:0] index;
    logic [tag_width-1:0]   req_tag;

    assign index = addr[2+offset_width +: index_width];

    // bit 31 selects the uncached window, so an uncached fetch
    // still matches the line of its cached alias
    assign req_tag = {1'b0, addr[30 -: tag_width-1]};

    ////////////////////////////////////////////////////////////
    // one tag column and valid vector per way
    ////////////////////////////////////////////////////////////

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic [tag_width-1:0] tag_q [sets];
        logic [sets-1:0]      valid_q;

        always_ff @(posedge clk) begin
            if (we[w]) begin
                tag_q[index] <= req_tag;
            end
        end

        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                valid_q <= '0;
            end else if (we[w]) begin
                valid_q[index] <= 1'b1;
            end else if (invalidate[w]) begin
                valid_q[index] <= 1'b0;
            end
        end

        assign hit[w] = valid_q[index] && (tag_q[index] == req_tag);
    end

endmodule

// File: hw/icache_top.sv
// top of the two-way instruction cache, joining the pipeline and memory handshakes to the blocks
`timescale 1ns/1ps

module icache_top #(
    parameter int index_width  = 4,
    parameter int offset_width = 2
) (
    input  logic                            clk,
    input  logic                            rstn,
    // pipeline side
    input  logic                            valid,
    output logic                            ready,
    input  icache_pkg::addr_t               addr,
    input  logic                            opflag,
    input  icache_pkg::word_t               opcode,
    input  logic                            stall,
    input  logic                            flush,
    output icache_pkg::word_t               inst,
    output logic                            inst_valid,
    // memory side
    output logic                            mem_req,
    output icache_pkg::addr_t               mem_addr,
    input  logic                            mem_addr_ok,
    input  logic                            mem_data_ok,
    input  logic [(32 << offset_width)-1:0] mem_rdata
);
    import icache_pkg::*;

    addr_t    rbuf_addr;
    logic     rbuf_opflag;
    cacheop_t rbuf_op;
    logic     rbuf_barrier;
    logic     rbuf_uncached;
    logic     rbuf_way;
    logic     rbuf_we;
    logic     [1:0] hit;
    logic     victim;
    logic     use0;
    logic     use1;
    logic     [1:0] data_we;
    logic     [1:0] invalidate;
    logic     choose_way;
    logic     choose_return;
    logic     send_nop;
    word_t    array_word;
    word_t    return_word;

    ////////////////////////////////////////////////////////////
    // blocks
    ////////////////////////////////////////////////////////////

    icache_main_fsm i_main_fsm (
        .clk           (clk),
        .rstn          (rstn),
        .valid         (valid),
        .stall         (stall),
        .flush         (flush),
        .opflag        (opflag),
        .rbuf_opflag   (rbuf_opflag),
        .rbuf_op       (rbuf_op),
        .rbuf_barrier  (rbuf_barrier),
        .rbuf_uncached (rbuf_uncached),
        .rbuf_way      (rbuf_way),
        .hit           (hit),
        .victim        (victim),
        .mem_addr_ok   (mem_addr_ok),
        .mem_data_ok   (mem_data_ok),
        .ready         (ready),
        .inst_valid    (inst_valid),
        .mem_req       (mem_req),
        .rbuf_we       (rbuf_we),
        .use0          (use0),
        .use1          (use1),
        .data_we       (data_we),
        .invalidate    (invalidate),
        .choose_way    (choose_way),
        .choose_return (choose_return),
        .send_nop      (send_nop)
    );

    icache_req_buf i_req_buf (
        .clk           (clk),
        .rstn          (rstn),
        .we            (rbuf_we),
        .addr          (addr),
        .opflag        (opflag),
        .opcode        (opcode),
        .rbuf_addr     (rbuf_addr),
        .rbuf_opflag   (rbuf_opflag),
        .rbuf_op       (rbuf_op),
        .rbuf_barrier  (rbuf_barrier),
        .rbuf_uncached (rbuf_uncached),
        .rbuf_way      (rbuf_way)
    );

    // the tag array is written with the data array on refill
    icache_tagv_array #(
        .index_width  (index_width),
        .offset_width (offset_width)
    ) i_tagv_array (
        .clk        (clk),
        .rstn       (rstn),
        .addr       (rbuf_addr),
        .we         (data_we),
        .invalidate (invalidate),
        .hit        (hit)
    );

    icache_data_array #(
        .index_width  (index_width),
        .offset_width (offset_width)
    ) i_data_array (
        .clk   (clk),
        .addr  (rbuf_addr),
        .we    (data_we),
        .wline (mem_rdata),
        .way   (choose_way),
        .word  (array_word)
    );

    icache_lru #(
        .index_width (index_width)
    ) i_lru (
        .clk    (clk),
        .rstn   (rstn),
        .index  (rbuf_addr[2+offset_width +: index_width]),
        .use0   (use0),
        .use1   (use1),
        .victim (victim)
    );

    ////////////////////////////////////////////////////////////
    // memory address and result select
    ////////////////////////////////////////////////////////////

    assign mem_addr    = {rbuf_addr[31:2+offset_width], {(2 + offset_width){1'b0}}};

    // requested word forwarded straight from the returning line
    assign return_word = mem_rdata[{rbuf_addr[2 +: offset_width], 5'b0} +: 32];

    assign inst = send_nop      ? NOP_WORD :
                  choose_return ? return_word : array_word;

endmodule

// File: icache_top.f
hw/icache_pkg.sv
hw/icache_main_fsm.sv
hw/icache_req_buf.sv
hw/icache_tagv_array.sv
hw/icache_data_array.sv
hw/icache_lru.sv
hw/icache_top.sv
testbench/icache_tb_mem.sv
testbench/icache_tb.sv

// File: testbench/icache_tb.sv
// testbench of the instruction cache, random fetches and operations checked against a reference model
`timescale 1ns/1ps

module icache_tb;
    import icache_pkg::*;

    localparam int    index_width  = 4;
    localparam int    offset_width = 2;
    localparam int    sets         = 1 << index_width;
    localparam int    tag_lsb      = 2 + offset_width + index_width;
    localparam int    num_requests = 400;
    localparam int    cycle_limit  = 40 * num_requests;
    localparam word_t word_key     = 32'h5a3c_96e1;

    logic                            clk;
    logic                            rstn;
    logic                            valid;
    logic                            ready;
    addr_t                           addr;
    logic                            opflag;
    word_t                           opcode;
    logic                            stall;
    logic                            flush;
    word_t                           inst;
    logic                            inst_valid;
    logic                            mem_req;
    addr_t                           mem_addr;
    logic                            mem_addr_ok;
    logic                            mem_data_ok;
    logic [(32 << offset_width)-1:0] mem_rdata;
    logic [31:0]                     req_count;

    // reference model, two ways per set
    logic [30:tag_lsb] m_tag [sets][2];
    logic              m_valid [sets][2];
    logic              m_mru [sets];
    // line reads the model has asked memory for so far
    logic [31:0]       reads_expected;

    // three tags over four sets force conflicts and evictions
    int unsigned tag_pool [3] = '{32'h00010, 32'h00023, 32'h00101};
    string       test_name;
    int          cycles = 0;

    icache_top #(
        .index_width  (index_width),
        .offset_width (offset_width)
    ) i_icache_top (
        .clk         (clk),
        .rstn        (rstn),
        .valid       (valid),
        .ready       (ready),
        .addr        (addr),
        .opflag      (opflag),
        .opcode      (opcode),
        .stall       (stall),
        .flush       (flush),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata)
    );

    icache_tb_mem #(
        .offset_width (offset_width),
        .word_key     (word_key)
    ) i_tb_mem (
        .clk         (clk),
        .rstn        (rstn),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata),
        .req_count   (req_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            stop_run("timeout, the requests did not finish within the cycle limit");
        end
    end

    ////////////////////////////////////////////////////////////
    // checks and model helpers
    ////////////////////////////////////////////////////////////

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            stop_run($sformatf("error %s %s: expected %h, actual %h",
                               test_name, name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        assert (actual === expected) else begin
            stop_run($sformatf("error %s %s: expected %b, actual %b",
                               test_name, name, expected, actual));
        end
    endtask

    function automatic word_t memory_word(input addr_t a);
        return {a[31:2], 2'b00} ^ word_key;
    endfunction

    function automatic int set_of(input addr_t a);
        return int'(a[2+offset_width +: index_width]);
    endfunction

    // bit 31 is only the uncached window, so it is left out of the compare
    function automatic int model_hit_way(input addr_t a);
        int s;
        s = set_of(a);
        for (int w = 0; w < 2; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == a[30:tag_lsb]) begin
                return w;
            end
        end
        return -1;
    endfunction

    function automatic addr_t pool_addr(input logic unc);
        int unsigned r;
        addr_t       a;
        r = $urandom;
        a = addr_t'(tag_pool[r % 3]) << tag_lsb;
        a = a | (addr_t'((r / 3) % 4) << (2 + offset_width));
        a = a | (addr_t'((r / 12) % (1 << offset_width)) << 2);
        a[31] = unc;
        return a;
    endfunction

    ////////////////////////////////////////////////////////////
    // request sequences
    ////////////////////////////////////////////////////////////

    task automatic send_request(input addr_t a, input logic op, input word_t code);
        @(posedge clk);
        valid  <= 1'b1;
        addr   <= a;
        opflag <= op;
        opcode <= code;
        @(negedge clk);
        while (!ready) @(negedge clk);
        @(posedge clk);
        valid  <= 1'b0;
        opflag <= 1'b0;
    endtask

    task automatic run_fetch(input addr_t a, input logic do_flush, input int stall_len);
        int          s;
        int          way;
        int          v;
        logic [31:0] count_before;
        word_t       expected;
        addr_t       line_base;
        s            = set_of(a);
        way          = model_hit_way(a);
        expected     = memory_word(a);
        line_base    = a & ~addr_t'((4 << offset_width) - 1);
        count_before = reads_expected;
        send_request(a, 1'b0, '0);
        if (do_flush) begin
            test_name = "flush";
            flush <= 1'b1;
            @(negedge clk);
            check_flag("inst_valid", 1'b1, inst_valid);
            check_word("inst", NOP_WORD, inst);
            @(posedge clk);
            flush <= 1'b0;
            @(negedge clk);
            check_flag("inst_valid", 1'b0, inst_valid);
            check_flag("ready", 1'b1, ready);
            check_word("mem requests", count_before, req_count);
        end else if (way >= 0 && !a[31]) begin
            test_name = "hit";
            // a competing request waits behind the stall
            if (stall_len > 0) begin
                stall <= 1'b1;
                valid <= 1'b1;
                addr  <= pool_addr(1'b0);
            end
            @(negedge clk);
            for (int i = 0; i < stall_len; i++) begin
                check_flag("inst_valid", 1'b1, inst_valid);
                check_word("inst", expected, inst);
                check_flag("ready", 1'b0, ready);
                @(posedge clk);
                if (i == stall_len - 1) begin
                    stall <= 1'b0;
                    valid <= 1'b0;
                end
                @(negedge clk);
            end
            check_flag("inst_valid", 1'b1, inst_valid);
            check_word("inst", expected, inst);
            check_flag("ready", 1'b1, ready);
            check_word("mem requests", count_before, req_count);
            m_mru[s] = (way == 1);
        end else begin
            test_name = a[31] ? "uncached" : "miss";
            @(negedge clk);
            check_flag("inst_valid", 1'b0, inst_valid);
            // the line read names the aligned line of the fetch
            do begin
                @(negedge clk);
                if (mem_req) begin
                    check_word("mem_addr", line_base, mem_addr);
                end
            end while (!inst_valid);
            check_word("inst", expected, inst);
            check_flag("ready", 1'b1, ready);
            check_word("mem requests", count_before + 32'd1, req_count);
            reads_expected = count_before + 32'd1;
            if (a[31]) begin
                if (way >= 0) begin
                    m_valid[s][way] = 1'b0;
                end
            end else begin
                v = m_mru[s] ? 0 : 1;
                m_tag[s][v]   = a[30:tag_lsb];
                m_valid[s][v] = 1'b1;
                m_mru[s]      = (v == 1);
            end
        end
    endtask

    task automatic run_operation(input addr_t a, input logic [1:0] code, input logic barrier);
        int          s;
        int          way;
        logic [31:0] count_before;
        s            = set_of(a);
        way          = model_hit_way(a);
        count_before = reads_expected;
        test_name    = barrier ? "barrier" : "operation";
        send_request(a, 1'b1, {barrier, 26'b0, code, 3'b000});
        @(negedge clk);
        check_flag("ready", 1'b0, ready);
        check_flag("inst_valid", 1'b0, inst_valid);
        check_flag("mem_req", 1'b0, mem_req);
        check_word("mem requests", count_before, req_count);
        if (!barrier) begin
            case (code)
                2'd0, 2'd1: m_valid[s][a[0]] = 1'b0;
                2'd2: begin
                    if (way >= 0) begin
                        m_valid[s][way] = 1'b0;
                    end
                end
                default: ;
            endcase
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int unsigned r;
        int unsigned bits;
        int          stall_len;
        addr_t       a;
        void'($urandom(32'hb59a));
        rstn           = 1'b0;
        valid          = 1'b0;
        addr           = '0;
        opflag         = 1'b0;
        opcode         = '0;
        stall          = 1'b0;
        flush          = 1'b0;
        reads_expected = '0;
        for (int i = 0; i < sets; i++) begin
            m_valid[i][0] = 1'b0;
            m_valid[i][1] = 1'b0;
            m_mru[i]      = 1'b0;
        end

        test_name = "reset";
        @(posedge clk);
        @(negedge clk);
        check_flag("mem_req", 1'b0, mem_req);
        check_flag("inst_valid", 1'b0, inst_valid);
        @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_flag("mem_req", 1'b0, mem_req);
        check_flag("inst_valid", 1'b0, inst_valid);
        @(negedge clk);
        check_flag("ready", 1'b1, ready);

        for (int n = 0; n < num_requests; n++) begin
            r    = $urandom % 100;
            bits = $urandom;
            if (r < 12) begin
                a    = pool_addr(1'b0);
                a[0] = bits[5];
                run_operation(a, bits[1:0], bits[4:2] == 3'd0);
            end else begin
                stall_len = (bits[1:0] == 2'd0) ? 1 + int'(bits[3:2]) : 0;
                run_fetch(pool_addr(r < 24), (bits[7:4] < 4'd2), stall_len);
            end
        end

        @(negedge clk);
        test_name = "end";
        check_flag("mem_req", 1'b0, mem_req);
        check_word("mem requests", reads_expected, req_count);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: testbench/icache_tb_mem.sv
// memory responder for the cache testbench, answering each line read after random delays
`timescale 1ns/1ps

module icache_tb_mem #(
    parameter int                offset_width = 2,
    parameter icache_pkg::word_t word_key     = 32'h5a3c_96e1
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            mem_req,
    input  icache_pkg::addr_t               mem_addr,
    output logic                            mem_addr_ok,
    output logic                            mem_data_ok,
    output logic [(32 << offset_width)-1:0] mem_rdata,
    output logic [31:0]                     req_count
);
    import icache_pkg::*;

    typedef enum logic [2:0] {
        ph_idle,
        ph_addr,
        ph_taken,
        ph_data,
        ph_done
    } phase_t;

    phase_t      phase;
    addr_t       line_addr;
    int unsigned wait_cycles;

    // every word is its own address scrambled by the key
    function automatic logic [(32 << offset_width)-1:0] line_of(input addr_t a);
        logic [(32 << offset_width)-1:0] line;
        for (int w = 0; w < (1 << offset_width); w++) begin
            line[w*32 +: 32] = (a + addr_t'(4 * w)) ^ word_key;
        end
        return line;
    endfunction

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase       <= ph_idle;
            line_addr   <= '0;
            wait_cycles <= 0;
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            mem_rdata   <= '0;
            req_count   <= '0;
        end else begin
            case (phase)
                ph_idle: begin
                    if (mem_req) begin
                        line_addr   <= mem_addr;
                        wait_cycles <= $urandom % 4;
                        req_count   <= req_count + 32'd1;
                        phase       <= ph_addr;
                    end
                end
                ph_addr: begin
                    if (wait_cycles == 0) begin
                        mem_addr_ok <= 1'b1;
                        phase       <= ph_taken;
                    end else begin
                        wait_cycles <= wait_cycles - 1;
                    end
                end
                // address accepted at this edge
                ph_taken: begin
                    mem_addr_ok <= 1'b0;
                    wait_cycles <= $urandom % 5;
                    phase       <= ph_data;
                end
                ph_data: begin
                    if (wait_cycles == 0) begin
                        mem_data_ok <= 1'b1;
                        mem_rdata   <= line_of(line_addr);
                        phase       <= ph_done;
                    end else begin
                        wait_cycles <= wait_cycles - 1;
                    end
                end
                default: begin
                    mem_data_ok <= 1'b0;
                    phase       <= ph_idle;
                end
            endcase
        end
    end

endmodule
